// ==== sim.f ====
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/pc_unit.sv
design/bus_unit.sv
design/cpu_datapath.sv
design/cpu_controller.sv
design/cpu_top.sv
+incdir+testbench
testbench/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module cpu_tb -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpu_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== testbench/cpu_tb_tests.svh ====
function automatic word_t fill_word(addr_t a);
    return {7'h53, a};
endfunction

function automatic word_t sext8(logic [7:0] imm);
    return {{8{imm[7]}}, imm};
endfunction

function automatic word_t shift_ref(word_t x, shift_e sh);
    case (sh)
        SH_LSL1: return x << 1;
        SH_LSR1: return x >> 1;
        SH_ASR1: return word_t'($signed(x) >>> 1);
        default: return x;
    endcase
endfunction

// branch rule from N, V and Z of a - b
function automatic logic cond_taken(cond_e c, word_t a, word_t b);
    int    diff;
    word_t d;
    logic  n;
    logic  z;
    logic  v;
    diff = int'($signed(a)) - int'($signed(b));
    d    = word_t'(diff);
    n    = d[15];
    z    = (d == '0);
    v    = (diff > 32767) || (diff < -32768);  // true difference outside 16-bit range
    case (c)
        COND_ALWAYS: return 1'b1;
        COND_EQ:     return z;
        COND_NE:     return !z;
        COND_LT:     return n != v;
        COND_LE:     return (n != v) || z;
        default:     return 1'b0;
    endcase
endfunction

function automatic word_t enc_mov_imm(reg_idx_t rn, logic [7:0] imm);
    return {OP_MOV, 2'b10, rn, imm};
endfunction

function automatic word_t enc_mov_reg(reg_idx_t rd, shift_e sh, reg_idx_t rm);
    return {OP_MOV, 2'b00, 3'b000, rd, sh, rm};
endfunction

function automatic word_t enc_alu(alu_op_e op, reg_idx_t rn, reg_idx_t rd, shift_e sh,
                                  reg_idx_t rm);
    return {OP_ALU, op, rn, rd, sh, rm};
endfunction

function automatic word_t enc_mem(opcode_e opc, reg_idx_t rn, reg_idx_t rd, logic [4:0] imm5);
    return {opc, 2'b00, rn, rd, imm5};
endfunction

function automatic word_t enc_branch(cond_e c, logic [7:0] off);
    return {OP_BRANCH, 2'b00, c, off};
endfunction

task automatic begin_test();
    for (int i = 0; i < MEM_WORDS; i++)
        mem[i] = fill_word(addr_t'(i));
    exp_trace.delete();
    exp_addr.delete();
    exp_data.delete();
    pc_build = RESET_PC;
    test_count++;
endtask

// place an instruction that will execute
task automatic emit(word_t instr);
    mem[pc_build] = instr;
    exp_trace.push_back(pc_build);
    pc_build    = pc_build + addr_t'(1);
    instr_total++;
endtask

// place an instruction that a taken branch jumps over
task automatic skip(word_t instr);
    mem[pc_build] = instr;
    pc_build    = pc_build + addr_t'(1);
    instr_total++;
endtask

task automatic expect_mem(addr_t a, word_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
endtask

task automatic store_result(reg_idx_t rd, int off, word_t expected);
    emit(enc_mem(OP_STR, 3'd7, rd, 5'(off)));
    expect_mem(DATA_BASE + addr_t'(off), expected);
endtask

task automatic load_reg(reg_idx_t r, logic [7:0] imm, int nsh, output word_t val);
    emit(enc_mov_imm(r, imm));
    for (int i = 0; i < nsh; i++)
        emit(enc_mov_reg(r, SH_LSL1, r));
    val = sext8(imm) << nsh;
endtask

task automatic run_program(string name);
    @(posedge clk);
    reset <= 1'b1;
    seen_trace.delete();
    repeat (RESET_CYCLES) @(posedge clk);
    if (mem_req || halted)
    begin
        protocol_errors++;
        $display("Error at %0t: mem_req or halted is high during reset in %s", $time, name);
    end
    reset <= 1'b0;
    @(posedge clk);
    while (!halted)
        @(posedge clk);
    repeat (4) @(posedge clk);
    foreach (exp_addr[i])
        compare_word($sformatf("%s mem[%h]", name, exp_addr[i]), exp_data[i], mem[exp_addr[i]]);
    if (seen_trace.size() != exp_trace.size())
    begin
        protocol_errors++;
        $display("Error at %0t: %s made %0d read cycles where %0d were expected",
                 $time, name, seen_trace.size(), exp_trace.size());
    end
    else
        foreach (exp_trace[i])
            compare_addr($sformatf("%s read %0d mem_addr", name, i), exp_trace[i], seen_trace[i]);
endtask

task automatic test_mov_str();
    logic [7:0] imms [3] = '{8'h7f, 8'h80, 8'h01};
    begin_test();
    emit(enc_mov_imm(3'd7, 8'h80));  // base register
    for (int k = 0; k < 3; k++)
    begin
        emit(enc_mov_imm(3'd1, imms[k]));
        store_result(3'd1, k, sext8(imms[k]));
    end
    emit({OP_HALT, 13'b0});
    run_program("mov_str");
endtask

task automatic test_alu_shift();
    logic [7:0] a_imm;
    logic [7:0] b_imm;
    word_t      av;
    word_t      sb;
    shift_e     sh;
    begin_test();
    a_imm = 8'(rand_bits(8));
    b_imm = 8'(rand_bits(8));
    av    = sext8(a_imm);
    emit(enc_mov_imm(3'd7, 8'h80));
    emit(enc_mov_imm(3'd1, a_imm));
    emit(enc_mov_imm(3'd2, b_imm));
    for (int s = 0; s < 4; s++)
    begin
        sh = shift_e'(s);
        sb = shift_ref(sext8(b_imm), sh);
        emit(enc_alu(ALU_ADD, 3'd1, 3'd3, sh, 3'd2));
        store_result(3'd3, 4 * s, av + sb);
        emit(enc_alu(ALU_AND, 3'd1, 3'd3, sh, 3'd2));
        store_result(3'd3, 4 * s + 1, av & sb);
        emit(enc_alu(ALU_MVN, 3'd0, 3'd3, sh, 3'd2));
        store_result(3'd3, 4 * s + 2, ~sb);
        emit(enc_mov_reg(3'd3, sh, 3'd2));
        store_result(3'd3, 4 * s + 3, sb);
    end
    emit({OP_HALT, 13'b0});
    run_program("alu_shift");
endtask

task automatic test_ldr();
    int         offs [4] = '{-4, -1, 0, 3};
    logic [7:0] add_imm;
    word_t      pre;
    addr_t      a;
    begin_test();
    add_imm = 8'(rand_bits(8));
    emit(enc_mov_imm(3'd7, 8'h80));
    emit(enc_mov_imm(3'd1, add_imm));
    for (int i = 0; i < 4; i++)
    begin
        a      = DATA_BASE + addr_t'(offs[i]);
        pre    = rand_bits(16);
        mem[a] = pre;
        emit(enc_mem(OP_LDR, 3'd7, 3'd2, 5'(offs[i])));
        exp_trace.push_back(a);  // the load read follows its fetch
        emit(enc_alu(ALU_ADD, 3'd1, 3'd3, SH_NONE, 3'd2));
        store_result(3'd3, 8 + i, pre + sext8(add_imm));
    end
    emit({OP_HALT, 13'b0});
    run_program("ldr");
endtask

// equal, less, greater, then 0x8000 - 1 which overflows
task automatic test_cmp_branch();
    logic [7:0] a_imm [4] = '{8'h05, 8'h03, 8'h09, 8'h40};
    int         a_sh [4]  = '{0, 0, 0, 9};
    logic [7:0] b_imm [4] = '{8'h05, 8'h09, 8'h03, 8'h01};
    word_t      av;
    word_t      bv;
    word_t      marker;
    int         off;
    begin_test();
    emit(enc_mov_imm(3'd7, 8'h80));
    emit(enc_mov_imm(3'd6, 8'h5a));
    for (int p = 0; p < 4; p++)
    begin
        load_reg(3'd1, a_imm[p], a_sh[p], av);
        load_reg(3'd2, b_imm[p], 0, bv);
        emit(enc_alu(ALU_CMP, 3'd1, 3'd0, SH_NONE, 3'd2));
        for (int c = 0; c < 5; c++)
        begin
            off    = p * 5 + c - 10;
            marker = enc_mem(OP_STR, 3'd7, 3'd6, 5'(off));
            emit(enc_branch(cond_e'(c), 8'h01));
            if (cond_taken(cond_e'(c), av, bv))
            begin
                skip(marker);
                expect_mem(DATA_BASE + addr_t'(off), fill_word(DATA_BASE + addr_t'(off)));
            end
            else
            begin
                emit(marker);
                expect_mem(DATA_BASE + addr_t'(off), 16'h005a);
            end
        end
    end
    emit({OP_HALT, 13'b0});
    run_program("cmp_branch");
endtask

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import cpu_isa_pkg::*;

    localparam int    MEM_WORDS     = 512;
    localparam int    CYCLES_PER_OP = 20;  // fetch and data access of 8 each, 4 control
    localparam int    RESET_CYCLES  = 16;
    localparam addr_t DATA_BASE     = 9'h180;  // low 9 bits of sext 0x80

    logic  clk = 1'b0;
    logic  reset;
    logic  mem_ack;
    word_t mem_rdata;
    logic  mem_req;
    logic  mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  halted;

    word_t       mem [MEM_WORDS];
    logic [31:0] lfsr_state = 32'h36b7aa69;
    int          word_errors = 0;
    int          addr_errors = 0;
    int          protocol_errors = 0;
    int          instr_total = 0;
    int          test_count = 0;
    int          cycles = 0;
    addr_t       pc_build;
    addr_t       exp_trace [$];
    addr_t       seen_trace [$];
    addr_t       exp_addr [$];
    word_t       exp_data [$];

    // memory model state
    logic        waiting;
    logic [1:0]  wait_cnt;

    // protocol monitor state
    logic        prev_req;
    logic        prev_write;
    addr_t       prev_addr;
    word_t       prev_wdata;

    cpu_top i_cpu_top (
        .clk, .reset, .mem_ack, .mem_rdata, .mem_req, .mem_write, .mem_addr,
        .mem_wdata, .halted
    );

    always #50 clk = ~clk;

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(int count);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < count; i++)
            r = {r[14:0], lfsr_step()};
        return r;
    endfunction

    task automatic compare_word(string name, word_t expected, word_t actual);
        if (expected !== actual)
        begin
            word_errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_addr(string name, addr_t expected, addr_t actual);
        if (expected !== actual)
        begin
            addr_errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // ack after 1 to 4 edges, write lands when ack rises
    always @(posedge clk)
    begin
        if (reset)
        begin
            mem_ack <= 1'b0;
            waiting <= 1'b0;
        end
        else if (mem_ack)
        begin
            if (!mem_req)
                mem_ack <= 1'b0;
        end
        else if (mem_req)
        begin
            if (!waiting)
            begin
                wait_cnt <= 2'(rand_bits(2));
                waiting  <= 1'b1;
            end
            else if (wait_cnt == 2'd0)
            begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[mem_addr];
                waiting   <= 1'b0;
                if (mem_write)
                    mem[mem_addr] = mem_wdata;
            end
            else
                wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (mem_req && !prev_req && mem_ack)
            begin
                protocol_errors++;
                $display("Error at %0t: memory request raised while ack is still high", $time);
            end
            if (mem_req && prev_req && (mem_addr !== prev_addr ||
                mem_write !== prev_write || mem_wdata !== prev_wdata))
            begin
                protocol_errors++;
                $display("Error at %0t: address, write or data changed during a request", $time);
            end
            if (mem_req && halted)
            begin
                protocol_errors++;
                $display("Error at %0t: memory request seen after the processor halted", $time);
            end
            if (mem_req && !prev_req && !mem_write)
                seen_trace.push_back(mem_addr);
        end
        prev_req   <= mem_req;
        prev_write <= mem_write;
        prev_addr  <= mem_addr;
        prev_wdata <= mem_wdata;
    end

    // watchdog scaled by the instructions built so far
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > instr_total * CYCLES_PER_OP + test_count * (RESET_CYCLES + 8))
        begin
            $display("Timeout after %0d cycles, the processor never halted", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    `include "cpu_tb_tests.svh"

    initial
    begin
        reset     <= 1'b1;
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        prev_req  <= 1'b0;
        test_mov_str();
        test_alu_shift();
        test_ldr();
        test_cmp_branch();
        $display("errors: word %0d, addr %0d, protocol %0d",
                 word_errors, addr_errors, protocol_errors);
        if (word_errors + addr_errors + protocol_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_ack,
    input  cpu_isa_pkg::word_t mem_rdata,
    output logic               mem_req,
    output logic               mem_write,
    output cpu_isa_pkg::addr_t mem_addr,
    output cpu_isa_pkg::word_t mem_wdata,
    output logic               halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic      bus_start;
    logic      bus_done;
    bus_kind_e bus_kind;
    logic      load_addr;
    word_t     rdata;
    logic      pc_inc;
    logic      branch_en;
    cond_e     cond;
    word_t     sximm8;
    word_t     sximm5;
    reg_idx_t  reg_idx;
    logic      reg_write;
    wb_sel_e   wb_sel;
    logic      load_a;
    logic      load_b;
    logic      load_c;
    logic      load_s;
    logic      a_zero;
    logic      b_imm;
    alu_op_e   alu_op;
    shift_e    shift;
    word_t     c_out;
    logic      n;
    logic      v;
    logic      z;
    addr_t     pc;

    cpu_controller i_cpu_controller (
        .clk, .reset, .bus_done, .rdata, .bus_start, .bus_kind, .load_addr,
        .pc_inc, .branch_en, .cond, .sximm8, .sximm5, .reg_idx, .reg_write,
        .wb_sel, .load_a, .load_b, .load_c, .load_s, .a_zero, .b_imm,
        .alu_op, .shift, .halted
    );

    cpu_datapath i_cpu_datapath (
        .clk, .reset, .reg_idx, .reg_write, .wb_sel, .load_a, .load_b,
        .load_c, .load_s, .a_zero, .b_imm, .alu_op, .shift, .sximm8,
        .sximm5, .mdata(rdata), .c_out, .n, .v, .z
    );

    pc_unit i_pc_unit (
        .clk, .reset, .pc_inc, .branch_en, .cond, .sximm8, .n, .v, .z, .pc
    );

    bus_unit i_bus_unit (
        .clk, .reset, .bus_start, .bus_kind, .load_addr, .pc, .c_in(c_out),
        .bus_done, .rdata, .mem_req, .mem_write, .mem_addr, .mem_wdata,
        .mem_ack, .mem_rdata
    );

endmodule

// ==== design/cpu_controller.sv ====
`timescale 1ns/1ps

module cpu_controller (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bus_done,
    input  cpu_isa_pkg::word_t     rdata,
    output logic                   bus_start,
    output cpu_ctrl_pkg::bus_kind_e bus_kind,
    output logic                   load_addr,
    output logic                   pc_inc,
    output logic                   branch_en,
    output cpu_isa_pkg::cond_e     cond,
    output cpu_isa_pkg::word_t     sximm8,
    output cpu_isa_pkg::word_t     sximm5,
    output cpu_isa_pkg::reg_idx_t  reg_idx,
    output logic                   reg_write,
    output cpu_ctrl_pkg::wb_sel_e  wb_sel,
    output logic                   load_a,
    output logic                   load_b,
    output logic                   load_c,
    output logic                   load_s,
    output logic                   a_zero,
    output logic                   b_imm,
    output cpu_isa_pkg::alu_op_e   alu_op,
    output cpu_isa_pkg::shift_e    shift,
    output logic                   halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    word_t       ir;
    logic        bus_pending;  // a memory cycle is in flight
    logic        data_pass;    // second EXECUTE of STR, moves Rd into C

    opcode_e     opcode;
    logic [1:0]  op;
    reg_idx_t    rn;
    reg_idx_t    rd;
    reg_idx_t    rm;
    shift_e      ir_shift;
    alu_op_e     ir_alu_op;
    logic        mov_imm;
    logic        is_mem;

    assign opcode    = opcode_e'(ir[15:13]);
    assign op        = ir[12:11];
    assign rn        = ir[10:8];
    assign rd        = ir[7:5];
    assign rm        = ir[2:0];
    assign ir_shift  = shift_e'(ir[4:3]);
    assign ir_alu_op = alu_op_e'(op);
    assign mov_imm   = (opcode == OP_MOV) && (op == 2'b10);
    assign is_mem    = (opcode == OP_LDR) || (opcode == OP_STR);

    assign cond   = cond_e'(ir[10:8]);
    assign sximm8 = {{8{ir[7]}}, ir[7:0]};
    assign sximm5 = {{11{ir[4]}}, ir[4:0]};

    always_ff @(posedge clk)
    begin
        if (state == S_FETCH && bus_done)
            ir <= rdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= S_FETCH;
            bus_pending <= 1'b0;
            data_pass   <= 1'b0;
            halted      <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            data_pass <= (state == S_MEM_ADDR) && (opcode == OP_STR);
            halted    <= halted || (state == S_HALT);
            if (bus_start)
                bus_pending <= 1'b1;
            else if (bus_done)
                bus_pending <= 1'b0;
        end
    end

    always_comb
    begin
        next_state = state;
        bus_start  = 1'b0;
        bus_kind   = BUS_FETCH;
        load_addr  = 1'b0;
        pc_inc     = 1'b0;
        branch_en  = 1'b0;
        reg_idx    = rd;
        reg_write  = 1'b0;
        wb_sel     = WB_ALU_C;
        load_a     = 1'b0;
        load_b     = 1'b0;
        load_c     = 1'b0;
        load_s     = 1'b0;
        a_zero     = 1'b0;
        b_imm      = 1'b0;
        alu_op     = ALU_ADD;
        shift      = SH_NONE;
        case (state)
            S_FETCH:
            begin
                bus_start = !bus_pending;
                if (bus_done)
                begin
                    pc_inc     = 1'b1;
                    next_state = S_DECODE;
                end
            end
            S_DECODE:
            begin
                case (opcode)
                    OP_MOV:
                    begin
                        if (op == 2'b10)
                            next_state = S_WRITE_BACK;
                        else if (op == 2'b00)
                            next_state = S_READ_B;  // no Rn operand
                        else
                            next_state = S_HALT;
                    end
                    OP_ALU:    next_state = S_READ_A;
                    OP_LDR,
                    OP_STR:    next_state = (op == 2'b00) ? S_READ_A : S_HALT;
                    OP_BRANCH: next_state = (op == 2'b00) ? S_BRANCH : S_HALT;
                    default:   next_state = S_HALT;  // HALT and unknown opcodes
                endcase
            end
            S_READ_A:
            begin
                reg_idx    = rn;
                load_a     = 1'b1;
                next_state = is_mem ? S_EXECUTE : S_READ_B;
            end
            S_READ_B:
            begin
                reg_idx    = rm;
                load_b     = 1'b1;
                next_state = S_EXECUTE;
            end
            S_EXECUTE:
            begin
                load_c = 1'b1;
                if (is_mem)
                begin
                    a_zero     = data_pass;
                    b_imm      = !data_pass;  // Rn + sximm5 on the first pass
                    next_state = data_pass ? S_MEM_ACCESS : S_MEM_ADDR;
                end
                else
                begin
                    shift      = ir_shift;
                    a_zero     = (opcode == OP_MOV);
                    next_state = S_WRITE_BACK;
                    if (opcode == OP_ALU)
                    begin
                        alu_op = ir_alu_op;
                        load_c = (ir_alu_op != ALU_CMP);
                        load_s = (ir_alu_op == ALU_CMP);
                    end
                end
            end
            S_MEM_ADDR:
            begin
                load_addr = 1'b1;
                if (opcode == OP_STR)
                begin
                    load_b     = 1'b1;  // store data from Rd
                    next_state = S_EXECUTE;
                end
                else
                    next_state = S_MEM_ACCESS;
            end
            S_MEM_ACCESS:
            begin
                bus_kind  = (opcode == OP_STR) ? BUS_STORE : BUS_LOAD;
                bus_start = !bus_pending;
                if (bus_done)
                    next_state = (opcode == OP_LDR) ? S_WRITE_BACK : S_FETCH;
            end
            S_WRITE_BACK:
            begin
                next_state = S_FETCH;
                if (mov_imm)
                begin
                    reg_idx   = rn;
                    wb_sel    = WB_IMM8;
                    reg_write = 1'b1;
                end
                else if (opcode == OP_LDR)
                begin
                    wb_sel    = WB_MDATA;
                    reg_write = 1'b1;
                end
                else
                    reg_write = !((opcode == OP_ALU) && (ir_alu_op == ALU_CMP));
            end
            S_BRANCH:
            begin
                branch_en  = 1'b1;  // pc unit decides if taken
                next_state = S_FETCH;
            end
            S_HALT:  next_state = S_HALT;
            default: next_state = S_HALT;
        endcase
    end

endmodule

// ==== design/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::reg_idx_t reg_idx,
    input  logic                  reg_write,
    input  cpu_ctrl_pkg::wb_sel_e wb_sel,
    input  logic                  load_a,
    input  logic                  load_b,
    input  logic                  load_c,
    input  logic                  load_s,
    input  logic                  a_zero,
    input  logic                  b_imm,
    input  cpu_isa_pkg::alu_op_e  alu_op,
    input  cpu_isa_pkg::shift_e   shift,
    input  cpu_isa_pkg::word_t    sximm8,
    input  cpu_isa_pkg::word_t    sximm5,
    input  cpu_isa_pkg::word_t    mdata,
    output cpu_isa_pkg::word_t    c_out,
    output logic                  n,
    output logic                  v,
    output logic                  z
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t regs [NUM_REGS];
    word_t a;
    word_t b;
    word_t wb_data;
    word_t b_shift;
    word_t ain;
    word_t bin;
    word_t alu_out;

    always_comb
    begin
        case (wb_sel)
            WB_IMM8:  wb_data = sximm8;
            WB_MDATA: wb_data = mdata;
            default:  wb_data = c_out;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reg_write)
            regs[reg_idx] <= wb_data;
        if (load_a)
            a <= regs[reg_idx];
        if (load_b)
            b <= regs[reg_idx];
        if (load_c)
            c_out <= alu_out;
    end

    always_comb
    begin
        case (shift)
            SH_LSL1: b_shift = {b[WORD_WIDTH-2:0], 1'b0};
            SH_LSR1: b_shift = {1'b0, b[WORD_WIDTH-1:1]};
            SH_ASR1: b_shift = {b[WORD_WIDTH-1], b[WORD_WIDTH-1:1]};
            default: b_shift = b;
        endcase
    end

    assign ain = a_zero ? '0 : a;
    assign bin = b_imm ? sximm5 : b_shift;

    always_comb
    begin
        case (alu_op)
            ALU_CMP: alu_out = ain - bin;
            ALU_AND: alu_out = ain & bin;
            ALU_MVN: alu_out = ~bin;
            default: alu_out = ain + bin;
        endcase
    end

    // status from CMP only
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            n <= 1'b0;
            v <= 1'b0;
            z <= 1'b0;
        end
        else if (load_s)
        begin
            n <= alu_out[WORD_WIDTH-1];
            z <= (alu_out == '0);
            // operands of opposite sign and result sign differs from ain
            v <= (ain[WORD_WIDTH-1] ^ bin[WORD_WIDTH-1]) &
                 (alu_out[WORD_WIDTH-1] ^ ain[WORD_WIDTH-1]);
        end
    end

endmodule

// ==== design/bus_unit.sv ====
`timescale 1ns/1ps

module bus_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    bus_start,
    input  cpu_ctrl_pkg::bus_kind_e bus_kind,
    input  logic                    load_addr,
    input  cpu_isa_pkg::addr_t      pc,
    input  cpu_isa_pkg::word_t      c_in,
    output logic                    bus_done,
    output cpu_isa_pkg::word_t      rdata,
    output logic                    mem_req,
    output logic                    mem_write,
    output cpu_isa_pkg::addr_t      mem_addr,
    output cpu_isa_pkg::word_t      mem_wdata,
    input  logic                    mem_ack,
    input  cpu_isa_pkg::word_t      mem_rdata
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    typedef enum logic [1:0] {
        BU_IDLE,
        BU_REQ,
        BU_WAIT_ACK_LOW
    } bus_state_e;

    bus_state_e state;
    addr_t      data_addr;

    always_ff @(posedge clk)
    begin
        if (load_addr)
            data_addr <= c_in[ADDR_WIDTH-1:0];
        if (state == BU_IDLE && bus_start)
        begin
            mem_addr  <= (bus_kind == BUS_FETCH) ? pc : data_addr;
            mem_wdata <= c_in;  // held for the whole request
        end
        if (state == BU_REQ && mem_ack)
            rdata <= mem_rdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= BU_IDLE;
            mem_req   <= 1'b0;
            mem_write <= 1'b0;
            bus_done  <= 1'b0;
        end
        else
        begin
            bus_done <= 1'b0;
            case (state)
                BU_IDLE:
                begin
                    if (bus_start)
                    begin
                        mem_req   <= 1'b1;
                        mem_write <= (bus_kind == BUS_STORE);
                        state     <= BU_REQ;
                    end
                end
                BU_REQ:
                begin
                    if (mem_ack)
                    begin
                        mem_req   <= 1'b0;
                        mem_write <= 1'b0;
                        state     <= BU_WAIT_ACK_LOW;
                    end
                end
                BU_WAIT_ACK_LOW:
                begin
                    if (!mem_ack)
                    begin
                        bus_done <= 1'b1;  // memory has closed the cycle
                        state    <= BU_IDLE;
                    end
                end
                default: state <= BU_IDLE;
            endcase
        end
    end

endmodule

// ==== design/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               pc_inc,
    input  logic               branch_en,
    input  cpu_isa_pkg::cond_e cond,
    input  cpu_isa_pkg::word_t sximm8,
    input  logic               n,
    input  logic               v,
    input  logic               z,
    output cpu_isa_pkg::addr_t pc
);
    import cpu_isa_pkg::*;

    logic taken;

    always_comb
    begin
        case (cond)
            COND_ALWAYS: taken = 1'b1;
            COND_EQ:     taken = z;
            COND_NE:     taken = !z;
            COND_LT:     taken = n ^ v;
            COND_LE:     taken = (n ^ v) | z;
            default:     taken = 1'b0;  // unknown condition
        endcase
    end

    // pc already points past the branch when branch_en arrives
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= RESET_PC;
        else if (pc_inc)
            pc <= pc + addr_t'(1);
        else if (branch_en && taken)
            pc <= pc + sximm8[ADDR_WIDTH-1:0];
    end

endmodule

// ==== design/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    typedef enum logic [3:0] {
        S_FETCH,
        S_DECODE,
        S_READ_A,
        S_READ_B,
        S_EXECUTE,
        S_WRITE_BACK,
        S_MEM_ADDR,
        S_MEM_ACCESS,
        S_BRANCH,
        S_HALT
    } ctrl_state_e;

    // kind of memory cycle asked of the bus unit
    typedef enum logic [1:0] {
        BUS_FETCH,
        BUS_LOAD,
        BUS_STORE
    } bus_kind_e;

    // register file write source
    typedef enum logic [1:0] {
        WB_ALU_C,
        WB_IMM8,
        WB_MDATA
    } wb_sel_e;

endpackage

// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    localparam int WORD_WIDTH = 16;
    localparam int ADDR_WIDTH = 9;
    localparam int NUM_REGS   = 8;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [2:0]            reg_idx_t;

    localparam addr_t RESET_PC = '0;  // first fetch address

    // instruction bits 15..13
    typedef enum logic [2:0] {
        OP_BRANCH = 3'b001,
        OP_LDR    = 3'b011,
        OP_STR    = 3'b100,
        OP_ALU    = 3'b101,
        OP_MOV    = 3'b110,
        OP_HALT   = 3'b111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_CMP = 2'b01,  // flags only
        ALU_AND = 2'b10,
        ALU_MVN = 2'b11
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL1 = 2'b01,
        SH_LSR1 = 2'b10,
        SH_ASR1 = 2'b11
    } shift_e;

    // branch condition, sits in the Rn field
    typedef enum logic [2:0] {
        COND_ALWAYS = 3'b000,
        COND_EQ     = 3'b001,
        COND_NE     = 3'b010,
        COND_LT     = 3'b011,
        COND_LE     = 3'b100
    } cond_e;

endpackage
